// File: source/mac_types_pkg.sv
// MAC array data types
package mac_types_pkg;

   // Chain geometry
   localparam int N_TILES     = 4;                  // Tiles in the systolic chain

   // Datapath widths
   localparam int WID_W       = 16;                 // Weight word
   localparam int WID_ACT     = 16;                 // Activation word
   localparam int WID_P       = 48;                 // Partial sum, DSP P width

   // Memory address widths
   localparam int WID_WADDR   = 10;                 // 1024 weights per tile
   localparam int WID_ACTADDR = 6;                  // 64 activations per tile

   localparam int W_DEPTH     = 1 << WID_WADDR;
   localparam int ACT_DEPTH   = 1 << WID_ACTADDR;

   // Data words, all unsigned
   typedef logic [WID_W-1:0]         weight_t;
   typedef logic [WID_ACT-1:0]       act_t;
   typedef logic [WID_P-1:0]         psum_t;

   // Addresses
   typedef logic [WID_WADDR-1:0]     waddr_t;
   typedef logic [WID_ACTADDR-1:0]   act_addr_t;
   typedef logic [WID_ACTADDR-2:0]   act_pair_addr_t;   // Even/odd pair select

   // Double-width activation write, high half goes to the odd word
   typedef logic [2*WID_ACT-1:0]     act_pair_t;

   // Selects the tile that takes an activation write
   typedef logic [$clog2(N_TILES)-1:0] tile_idx_t;

endpackage

// File: source/mac_ctrl_pkg.sv
// MAC array control encodings
package mac_ctrl_pkg;

   // Step opcode, travels with the read addresses down the chain
   typedef enum logic [1:0] {
      OP_NOP      = 2'd0,   // Bubble, no work
      OP_MUL      = 2'd1,   // Multiply and add cascade
      OP_MUL_LAST = 2'd2    // Same, final step of a run
   } mac_op_e;

   // Sequencer FSM
   typedef enum logic {
      SEQ_IDLE = 1'b0,
      SEQ_RUN  = 1'b1
   } seq_state_e;

   // Weight read: array register plus output register
   localparam int WROM_LAT = 2;

   // Feed to registered P in tile 0: weight latency, product, P
   localparam int MAC_LAT  = 4;

endpackage

// File: source/tile_feed_if.sv
// Tile feed bundle
interface tile_feed_if ();
   import mac_types_pkg::*;
   import mac_ctrl_pkg::*;

   // Read side, skewed one cycle per tile
   waddr_t         w_rd_addr;
   act_addr_t      act_rd_addr;
   mac_op_e        op;

   // Write side, reaches every tile in the same cycle
   logic           act_wr_en;
   tile_idx_t      act_wr_tile;
   act_pair_addr_t act_wr_addr;
   act_pair_t      act_wr_data;

   modport src (
      output w_rd_addr, act_rd_addr, op,
      output act_wr_en, act_wr_tile, act_wr_addr, act_wr_data
   );

   modport snk (
      input  w_rd_addr, act_rd_addr, op,
      input  act_wr_en, act_wr_tile, act_wr_addr, act_wr_data
   );

endinterface

// File: source/act_buffer.sv
// Activation buffer
module act_buffer (
   input  logic                          clk_h,
   input  logic                          rst_n,
   input  logic                          wr_en,
   input  mac_types_pkg::act_pair_addr_t wr_addr,
   input  mac_types_pkg::act_pair_t      wr_data,
   input  mac_types_pkg::act_addr_t      rd_addr,
   output mac_types_pkg::act_t           rd_data
);
   import mac_types_pkg::*;

   // Distributed-RAM style store, no reset on contents
   act_t mem [ACT_DEPTH];

   // Both halves land in the same cycle
   always_ff @(posedge clk_h) begin
      if (wr_en) begin
         mem[{wr_addr, 1'b0}] <= wr_data[WID_ACT-1:0];          // Low half, even word
         mem[{wr_addr, 1'b1}] <= wr_data[2*WID_ACT-1:WID_ACT];  // High half, odd word
      end
   end

   // Asynchronous read port, the slice registers it
   assign rd_data = mem[rd_addr];

   // A write with an unknown pair address would corrupt an arbitrary pair
   a_wr_addr_known: assert property (
      @(posedge clk_h) disable iff (!rst_n)
      wr_en |-> !$isunknown(wr_addr)
   ) else $error("act_buffer write with unknown address");

endmodule

// File: source/weight_rom.sv
// Weight ROM
module weight_rom #(
   parameter int TILE_IDX = 0
) (
   input  logic                  clk_h,
   input  logic                  rst_n,
   input  mac_types_pkg::waddr_t rd_addr,
   output mac_types_pkg::weight_t rd_data
);
   import mac_types_pkg::*;
   import mac_ctrl_pkg::*;

   weight_t rom     [W_DEPTH];
   weight_t rd_pipe [WROM_LAT];   // [0] array read, rest output registers

   // Contents rule: word a of tile t is a + 16*t + 1, low 16 bits
   initial begin
      for (int a = 0; a < W_DEPTH; a++) begin
         rom[a] = weight_t'(a + 16 * TILE_IDX + 1);
      end
   end

   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < WROM_LAT; i++) begin
            rd_pipe[i] <= '0;
         end
      end else begin
         rd_pipe[0] <= rom[rd_addr];              // Registered array read
         for (int i = 1; i < WROM_LAT; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];           // Output register
         end
      end
   end

   assign rd_data = rd_pipe[WROM_LAT-1];

endmodule

// File: source/mac_slice.sv
// Multiply and cascade add slice
module mac_slice (
   input  logic                   clk_h,
   input  logic                   rst_n,
   input  mac_types_pkg::weight_t weight,
   input  mac_types_pkg::act_t    act,
   input  mac_ctrl_pkg::mac_op_e  op_in,
   input  mac_types_pkg::psum_t   psum_in,
   output mac_types_pkg::psum_t   psum,
   output mac_ctrl_pkg::mac_op_e  op_out
);
   import mac_types_pkg::*;
   import mac_ctrl_pkg::*;

   act_t                     act_pipe [WROM_LAT];  // Matches the weight read latency
   mac_op_e                  op_pipe  [MAC_LAT];   // Opcode rides along to P
   logic [WID_W+WID_ACT-1:0] prod_q;               // M register
   mac_op_e                  op_a;                 // Op aligned with weight
   mac_op_e                  op_m;                 // Op at the M stage

   assign op_a   = op_pipe[WROM_LAT-1];
   assign op_m   = op_pipe[MAC_LAT-2];
   assign op_out = op_pipe[MAC_LAT-1];   // P-stage op

   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < WROM_LAT; i++) begin
            act_pipe[i] <= '0;
         end
         for (int i = 0; i < MAC_LAT; i++) begin
            op_pipe[i] <= OP_NOP;
         end
         prod_q <= '0;
         psum   <= '0;
      end else begin
         // Activation delay line
         act_pipe[0] <= act;
         for (int i = 1; i < WROM_LAT; i++) begin
            act_pipe[i] <= act_pipe[i-1];
         end

         // Opcode delay line
         op_pipe[0] <= op_in;
         for (int i = 1; i < MAC_LAT; i++) begin
            op_pipe[i] <= op_pipe[i-1];
         end

         // Bubbles never load the multiplier output
         if (op_a == OP_NOP) begin
            prod_q <= '0;
         end else begin
            prod_q <= weight * act_pipe[WROM_LAT-1];
         end

         // Cascade arrives together with this tile's product
         if (op_m == OP_NOP) begin
            psum <= psum_in;                      // Idle tile passes cascade through
         end else begin
            psum <= psum_in + WID_P'(prod_q);
         end
      end
   end

   // Opcode drives the drain decode, must stay clean after reset
   a_op_known: assert property (
      @(posedge clk_h) disable iff (!rst_n)
      !$isunknown(op_out)
   ) else $error("mac_slice op_out unknown");

endmodule

// File: source/super_tile.sv
// MAC super tile
module super_tile #(
   parameter int TILE_IDX = 0
) (
   input  logic                  clk_h,
   input  logic                  rst_n,
   tile_feed_if.snk              feed_in,
   tile_feed_if.src              feed_out,
   input  mac_types_pkg::psum_t  psum_in,
   output mac_types_pkg::psum_t  psum,
   output mac_ctrl_pkg::mac_op_e op_out
);
   import mac_types_pkg::*;
   import mac_ctrl_pkg::*;

   weight_t w_rd_data;
   act_t    act_rd_data;
   logic    buf_wr_en;

   // Only the addressed tile takes the write
   assign buf_wr_en = feed_in.act_wr_en && (feed_in.act_wr_tile == tile_idx_t'(TILE_IDX));

   act_buffer u_act (
      .clk_h   (clk_h),
      .rst_n   (rst_n),
      .wr_en   (buf_wr_en),
      .wr_addr (feed_in.act_wr_addr),
      .wr_data (feed_in.act_wr_data),
      .rd_addr (feed_in.act_rd_addr),
      .rd_data (act_rd_data)
   );

   weight_rom #(.TILE_IDX(TILE_IDX)) u_wrom (
      .clk_h   (clk_h),
      .rst_n   (rst_n),
      .rd_addr (feed_in.w_rd_addr),
      .rd_data (w_rd_data)
   );

   mac_slice u_mac (
      .clk_h   (clk_h),
      .rst_n   (rst_n),
      .weight  (w_rd_data),
      .act     (act_rd_data),
      .op_in   (feed_in.op),
      .psum_in (psum_in),
      .psum    (psum),
      .op_out  (op_out)
   );

   // One cycle of skew per tile on the read side
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         feed_out.w_rd_addr   <= '0;
         feed_out.act_rd_addr <= '0;
         feed_out.op          <= OP_NOP;
      end else begin
         feed_out.w_rd_addr   <= feed_in.w_rd_addr;
         feed_out.act_rd_addr <= feed_in.act_rd_addr;
         feed_out.op          <= feed_in.op;
      end
   end

   // Write side is broadcast, no skew
   assign feed_out.act_wr_en   = feed_in.act_wr_en;
   assign feed_out.act_wr_tile = feed_in.act_wr_tile;
   assign feed_out.act_wr_addr = feed_in.act_wr_addr;
   assign feed_out.act_wr_data = feed_in.act_wr_data;

endmodule

// File: source/feed_sequencer.sv
// Feed sequencer
module feed_sequencer (
   input  logic                                  clk_h,
   input  logic                                  rst_n,
   input  logic                                  start,
   input  mac_types_pkg::waddr_t                 w_base,
   input  mac_types_pkg::act_addr_t              act_base,
   input  logic [mac_types_pkg::WID_ACTADDR-1:0] run_len,
   input  logic                                  act_wr_en,
   input  mac_types_pkg::tile_idx_t              act_wr_tile,
   input  mac_types_pkg::act_pair_addr_t         act_wr_addr,
   input  mac_types_pkg::act_pair_t              act_wr_data,
   output logic                                  busy,
   tile_feed_if.src                              feed
);
   import mac_types_pkg::*;
   import mac_ctrl_pkg::*;

   seq_state_e             state;
   logic                   accept;        // Start seen while idle
   logic [WID_ACTADDR-1:0] steps_left;    // Steps after the one on the bus
   waddr_t                 w_addr_q;
   act_addr_t              act_addr_q;
   mac_op_e                op_q;
   logic                   wr_en_q;
   tile_idx_t              wr_tile_q;
   act_pair_addr_t         wr_addr_q;
   act_pair_t              wr_data_q;

   assign accept = start && (state == SEQ_IDLE);
   assign busy   = (state == SEQ_RUN);

   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         state      <= SEQ_IDLE;
         steps_left <= '0;
         w_addr_q   <= '0;
         act_addr_q <= '0;
         op_q       <= OP_NOP;
      end else if (accept) begin
         state      <= SEQ_RUN;
         w_addr_q   <= w_base;                  // Step 0 goes out next cycle
         act_addr_q <= act_base;
         steps_left <= run_len - 1'b1;
         op_q       <= (run_len == 1) ? OP_MUL_LAST : OP_MUL;
      end else if (state == SEQ_RUN) begin
         if (steps_left == '0) begin
            state <= SEQ_IDLE;                   // Last step is on the bus now
            op_q  <= OP_NOP;
         end else begin
            w_addr_q   <= w_addr_q + 1'b1;
            act_addr_q <= act_addr_q + 1'b1;     // Wraps modulo 64
            steps_left <= steps_left - 1'b1;
            op_q       <= (steps_left == 1) ? OP_MUL_LAST : OP_MUL;
         end
      end
   end

   // Write strobe and payload, one register stage before the broadcast
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         wr_en_q   <= 1'b0;
         wr_tile_q <= '0;
         wr_addr_q <= '0;
         wr_data_q <= '0;
      end else begin
         wr_en_q   <= act_wr_en;
         wr_tile_q <= act_wr_tile;
         wr_addr_q <= act_wr_addr;
         wr_data_q <= act_wr_data;
      end
   end

   assign feed.w_rd_addr   = w_addr_q;
   assign feed.act_rd_addr = act_addr_q;
   assign feed.op          = op_q;
   assign feed.act_wr_en   = wr_en_q;
   assign feed.act_wr_tile = wr_tile_q;
   assign feed.act_wr_addr = wr_addr_q;
   assign feed.act_wr_data = wr_data_q;

   // Zero-length run would count down from 63
   a_run_len_nonzero: assert property (
      @(posedge clk_h) disable iff (!rst_n)
      accept |-> (run_len != '0)
   ) else $error("feed_sequencer start with run_len of zero");

endmodule

// File: source/psum_drain.sv
// Partial sum drain
module psum_drain (
   input  logic                  clk_h,
   input  logic                  rst_n,
   input  mac_types_pkg::psum_t  psum,
   input  mac_ctrl_pkg::mac_op_e op,
   output mac_types_pkg::psum_t  result,
   output logic                  result_valid
);
   import mac_types_pkg::*;
   import mac_ctrl_pkg::*;

   psum_t acc_q;   // Running total over the current run

   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         acc_q        <= '0;
         result       <= '0;
         result_valid <= 1'b0;
      end else begin
         result_valid <= 1'b0;                  // One-cycle pulse
         case (op)
            OP_MUL: begin
               acc_q <= acc_q + psum;
            end
            OP_MUL_LAST: begin
               result       <= acc_q + psum;    // Final step folds in directly
               result_valid <= 1'b1;
               acc_q        <= '0;              // Ready for the next run
            end
            default: begin
               acc_q <= acc_q;                  // Bubble, hold
            end
         endcase
      end
   end

endmodule

// File: source/stile_array.sv
// Super tile MAC array
module stile_array (
   input  logic                                  clk_h,
   input  logic                                  rst_n,
   input  logic                                  start,
   input  mac_types_pkg::waddr_t                 w_base,
   input  mac_types_pkg::act_addr_t              act_base,
   input  logic [mac_types_pkg::WID_ACTADDR-1:0] run_len,
   input  logic                                  act_wr_en,
   input  mac_types_pkg::tile_idx_t              act_wr_tile,
   input  mac_types_pkg::act_pair_addr_t         act_wr_addr,
   input  mac_types_pkg::act_pair_t              act_wr_data,
   output logic                                  busy,
   output mac_types_pkg::psum_t                  result,
   output logic                                  result_valid
);
   import mac_types_pkg::*;
   import mac_ctrl_pkg::*;

   tile_feed_if feed [N_TILES+1] ();   // feed[i] enters tile i, last one is the chain tail
   psum_t       psum_c [N_TILES+1];    // Cascade between tiles
   mac_op_e     op_c   [N_TILES];      // P-stage op of each tile

   assign psum_c[0] = '0;              // Head tile adds zero

   feed_sequencer u_seq (
      .clk_h       (clk_h),
      .rst_n       (rst_n),
      .start       (start),
      .w_base      (w_base),
      .act_base    (act_base),
      .run_len     (run_len),
      .act_wr_en   (act_wr_en),
      .act_wr_tile (act_wr_tile),
      .act_wr_addr (act_wr_addr),
      .act_wr_data (act_wr_data),
      .busy        (busy),
      .feed        (feed[0].src)
   );

   for (genvar g = 0; g < N_TILES; g++) begin : g_tile
      super_tile #(.TILE_IDX(g)) u_tile (
         .clk_h    (clk_h),
         .rst_n    (rst_n),
         .feed_in  (feed[g].snk),
         .feed_out (feed[g+1].src),
         .psum_in  (psum_c[g]),
         .psum     (psum_c[g+1]),
         .op_out   (op_c[g])
      );
   end

   // Tail of the chain
   psum_drain u_drain (
      .clk_h        (clk_h),
      .rst_n        (rst_n),
      .psum         (psum_c[N_TILES]),
      .op           (op_c[N_TILES-1]),
      .result       (result),
      .result_valid (result_valid)
   );

endmodule

// File: bench/stile_array_tb.sv
// MAC array testbench
module stile_array_tb;
   import mac_types_pkg::*;
   import mac_ctrl_pkg::*;

   localparam int N_RUNS = 9;
   localparam int QUIET  = 24;   // Cycles after a result that must stay free of pulses

   // Columns: w_base, act_base, run_len, write mode (0 none, 1 all tiles, 2 one tile),
   // tile for mode 2, second start while busy
   int tbl [N_RUNS][6] = '{
      '{   0,  0,  1, 1, 0, 0},   // Single step on fresh activations
      '{   5,  2,  8, 0, 0, 0},
      '{1020, 58, 12, 0, 0, 0},   // Weight and activation addresses wrap
      '{ 300,  7,  5, 1, 0, 0},   // Odd base, reads high halves
      '{  77, 33, 31, 0, 0, 0},
      '{  12, 20, 20, 0, 0, 1},   // Restart attempt mid-run
      '{  40, 10, 16, 0, 0, 0},
      '{  40, 10, 16, 2, 2, 0},   // Same run again after tile 2 is rewritten
      '{ 900, 63, 63, 0, 0, 0}    // Longest run
   };

   logic                   clk_h;
   logic                   rst_n;
   logic                   start;
   waddr_t                 w_base;
   act_addr_t              act_base;
   logic [WID_ACTADDR-1:0] run_len;
   logic                   act_wr_en;
   tile_idx_t              act_wr_tile;
   act_pair_addr_t         act_wr_addr;
   act_pair_t              act_wr_data;
   logic                   busy;
   psum_t                  result;
   logic                   result_valid;

   act_t  act_model [N_TILES][ACT_DEPTH];   // Shadow of every buffer
   psum_t contrib [N_TILES];                // Per-tile share of the current run
   psum_t prev_contrib [N_TILES];
   psum_t prev_result;
   int    cyc;
   int    cyc_limit;

   stile_array dut0 (
      .clk_h        (clk_h),
      .rst_n        (rst_n),
      .start        (start),
      .w_base       (w_base),
      .act_base     (act_base),
      .run_len      (run_len),
      .act_wr_en    (act_wr_en),
      .act_wr_tile  (act_wr_tile),
      .act_wr_addr  (act_wr_addr),
      .act_wr_data  (act_wr_data),
      .busy         (busy),
      .result       (result),
      .result_valid (result_valid)
   );

   initial begin
      clk_h = 1'b0;
      forever #4 clk_h = ~clk_h;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("CHECKS FAILED");
      $fatal(1, "Stopped at first error");
   endtask

   // Watchdog
   always @(posedge clk_h) begin
      cyc <= cyc + 1;
      if (cyc > cyc_limit) fail_run("Timeout: the run went past its cycle limit");
   end

   // Weight word a of tile t
   function automatic weight_t weight_at(input int t, input int a);
      return weight_t'(a + 16 * t + 1);
   endfunction

   function automatic psum_t tile_sum(input int t, input int wb, input int ab, input int rl);
      psum_t s = '0;
      for (int k = 0; k < rl; k++) begin
         s = s + psum_t'(weight_at(t, (wb + k) % W_DEPTH))
               * psum_t'(act_model[t][(ab + k) % ACT_DEPTH]);
      end
      return s;
   endfunction

   // Fills every pair of one tile with random data
   task automatic write_acts(input int t);
      act_pair_t d;
      for (int p = 0; p < ACT_DEPTH / 2; p++) begin
         d = {act_t'($urandom), act_t'($urandom)};
         @(posedge clk_h);
         act_wr_en   <= 1'b1;
         act_wr_tile <= tile_idx_t'(t);
         act_wr_addr <= act_pair_addr_t'(p);
         act_wr_data <= d;
         act_model[t][2*p]   = d[WID_ACT-1:0];           // Even word takes the low half
         act_model[t][2*p+1] = d[2*WID_ACT-1:WID_ACT];
      end
      @(posedge clk_h);
      act_wr_en <= 1'b0;
      repeat (2) @(posedge clk_h);   // Registered write path settles
   endtask

   task automatic do_run(input int r);
      int    rl;
      int    k;
      int    hits;
      int    lat;
      psum_t got;
      psum_t exp_sum;
      rl = tbl[r][2];
      if (tbl[r][3] == 1) begin
         for (int t = 0; t < N_TILES; t++) write_acts(t);
      end else if (tbl[r][3] == 2) begin
         write_acts(tbl[r][4]);
      end
      exp_sum = '0;
      for (int t = 0; t < N_TILES; t++) begin
         contrib[t] = tile_sum(t, tbl[r][0], tbl[r][1], rl);
         exp_sum    = exp_sum + contrib[t];
      end
      @(posedge clk_h);
      start    <= 1'b1;
      w_base   <= waddr_t'(tbl[r][0]);
      act_base <= act_addr_t'(tbl[r][1]);
      run_len  <= 6'(rl);
      k    = 0;
      hits = 0;
      lat  = 0;
      got  = '0;
      while (hits == 0 || k < lat + QUIET) begin
         @(posedge clk_h);
         if (tbl[r][5] != 0 && k == 2) begin
            start   <= 1'b1;                 // Arrives while busy
            w_base  <= w_base + 10'd100;
            run_len <= 6'd3;
         end else begin
            start <= 1'b0;
         end
         @(negedge clk_h);
         k++;
         assert (busy == (k <= rl)) else fail_run($sformatf(
            "Mismatch at %0t: busy is %b in cycle %0d of a %0d-step run", $time, busy, k, rl));
         if (result_valid) begin
            if (hits == 0) begin
               lat = k;
               got = result;
            end
            hits++;
         end
         assert (hits > 0 || k < rl + N_TILES + MAC_LAT + QUIET)
            else fail_run("result_valid never arrived after a start");
      end
      assert (hits == 1) else fail_run($sformatf(
         "Mismatch at %0t: run %0d gave %0d result pulses", $time, r, hits));
      assert (lat == rl + N_TILES + MAC_LAT) else fail_run($sformatf(
         "Mismatch at %0t: run %0d result after %0d cycles", $time, r, lat));
      // Only the rewritten tile may move the total
      if (tbl[r][3] == 2) begin
         assert (got - prev_result == contrib[tbl[r][4]] - prev_contrib[tbl[r][4]])
            else fail_run($sformatf(
               "Mismatch at %0t: rewrite of tile %0d changed other tiles", $time, tbl[r][4]));
      end
      assert (got == exp_sum) else fail_run($sformatf(
         "Mismatch at %0t: run %0d result %h expected %h", $time, r, got, exp_sum));
      prev_result = got;
      for (int t = 0; t < N_TILES; t++) prev_contrib[t] = contrib[t];
   endtask

   initial begin
      void'($urandom(82));
      cyc         = 0;
      cyc_limit   = 200;
      rst_n       = 1'b0;
      start       = 1'b0;
      w_base      = '0;
      act_base    = '0;
      run_len     = '0;
      act_wr_en   = 1'b0;
      act_wr_tile = '0;
      act_wr_addr = '0;
      act_wr_data = '0;
      for (int r = 0; r < N_RUNS; r++) begin
         cyc_limit += 64 + tbl[r][2] + QUIET;
         if (tbl[r][3] != 0) cyc_limit += (tbl[r][3] == 1 ? N_TILES : 1) * (ACT_DEPTH / 2 + 3);
      end
      repeat (16) @(posedge clk_h);
      rst_n <= 1'b1;
      repeat (8) begin                      // Idle after reset
         @(negedge clk_h);
         assert (!busy && !result_valid) else fail_run($sformatf(
            "Mismatch at %0t: busy %b result_valid %b before any start", $time, busy,
            result_valid));
      end
      for (int r = 0; r < N_RUNS; r++) do_run(r);
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// File: filelist.f
source/mac_types_pkg.sv
source/mac_ctrl_pkg.sv
source/tile_feed_if.sv
source/act_buffer.sv
source/weight_rom.sv
source/mac_slice.sv
source/super_tile.sv
source/feed_sequencer.sv
source/psum_drain.sv
source/stile_array.sv
bench/stile_array_tb.sv

// File: Bender.yml
package:
  name: stile_array

sources:
  - source/mac_types_pkg.sv
  - source/mac_ctrl_pkg.sv
  - source/tile_feed_if.sv
  - source/act_buffer.sv
  - source/weight_rom.sv
  - source/mac_slice.sv
  - source/super_tile.sv
  - source/feed_sequencer.sv
  - source/psum_drain.sv
  - source/stile_array.sv
  - target: test
    files:
      - bench/stile_array_tb.sv
